/* bno_hub.sv */
`timescale 1ns/1ps

module bno_hub (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             int_n,
    input  logic             spi_busy,
    input  logic             spi_rx_valid,
    input  bno_pkg::byte_t   spi_rx_data,
    output logic             spi_start,
    output bno_pkg::byte_t   spi_tx_data,
    output logic             cs_n,
    output logic             ps0_wake,
    output logic             initialized,
    output logic             error,
    output logic             quat_valid,
    output bno_pkg::sample_t quat_w,
    output bno_pkg::sample_t quat_x,
    output bno_pkg::sample_t quat_y,
    output bno_pkg::sample_t quat_z,
    output logic             gyro_valid,
    output bno_pkg::sample_t gyro_x,
    output bno_pkg::sample_t gyro_y,
    output bno_pkg::sample_t gyro_z
);

    // Byte request paths between the two masters and the port
    logic           int_low;
    logic           byte_done;
    bno_pkg::byte_t rx_byte;
    logic           init_sel;
    logic           init_req;
    bno_pkg::byte_t init_byte;
    logic           rd_sel;
    logic           rd_req;

    bno_init_seq i_bno_init_seq (.*);

    shtp_report_reader i_shtp_report_reader (
        .enable (initialized),  // Reads start once config is sent
        .*
    );

    shtp_host_port i_shtp_host_port (.*);

endmodule

/* bno_init_seq.sv */
`timescale 1ns/1ps

module bno_init_seq (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           int_low,
    input  logic           byte_done,
    output logic           init_sel,
    output logic           init_req,
    output bno_pkg::byte_t init_byte,
    output logic           ps0_wake,     // Active low
    output logic           initialized,
    output logic           error
);

    bno_pkg::init_state_t        state;
    bno_pkg::cmd_t               cmd;         // Command in progress
    bno_pkg::byte_t              byte_idx;    // Byte within command
    logic [bno_pkg::DELAY_W-1:0] delay_cnt;
    logic                        last_byte;
    logic                        last_cmd;

    assign init_byte = bno_pkg::cmd_byte(cmd, byte_idx);  // Sampled by host port on req
    assign last_byte = (byte_idx == bno_pkg::cmd_len(cmd) - 8'd1);
    assign last_cmd  = (int'(cmd) == bno_pkg::NUM_CMDS - 1);

    // ==================================================
    // Sequencer FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= bno_pkg::INIT_WAIT_RESET;
            cmd         <= bno_pkg::CMD_PROD_ID;
            byte_idx    <= '0;
            delay_cnt   <= '0;
            init_sel    <= 1'b0;
            init_req    <= 1'b0;
            ps0_wake    <= 1'b1;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            init_req <= 1'b0;  // Single-cycle request
            case (state)
                bno_pkg::INIT_WAIT_RESET: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == bno_pkg::RESET_WAIT_CYCLES - 1) begin
                        delay_cnt <= '0;
                        state     <= bno_pkg::INIT_ARM;
                    end
                end
                bno_pkg::INIT_ARM: begin
                    if (int_low) begin
                        state <= bno_pkg::INIT_START;  // Hub already awake
                    end else begin
                        ps0_wake <= 1'b0;
                        state    <= bno_pkg::INIT_WAKE;
                    end
                end
                bno_pkg::INIT_WAKE: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == bno_pkg::WAKE_HOLD_CYCLES - 1) begin
                        delay_cnt <= '0;
                        state     <= bno_pkg::INIT_WAIT_INT;
                    end
                end
                bno_pkg::INIT_WAIT_INT: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (int_low) begin
                        delay_cnt <= '0;
                        state     <= bno_pkg::INIT_START;
                    end else if (delay_cnt == bno_pkg::INT_TIMEOUT_CYCLES - 1) begin
                        error    <= 1'b1;       // Sticky until reset
                        ps0_wake <= 1'b1;
                        state    <= bno_pkg::INIT_ERROR;
                    end
                end
                bno_pkg::INIT_START: begin
                    init_sel <= 1'b1;
                    ps0_wake <= 1'b1;  // Wake released as CS goes low
                    init_req <= 1'b1;
                    byte_idx <= '0;
                    state    <= bno_pkg::INIT_SEND;
                end
                bno_pkg::INIT_SEND: begin
                    if (byte_done && init_sel) begin
                        if (last_byte) begin
                            init_sel <= 1'b0;
                            state    <= bno_pkg::INIT_GAP;
                        end else begin
                            byte_idx <= byte_idx + 8'd1;
                            init_req <= 1'b1;
                        end
                    end
                end
                bno_pkg::INIT_GAP: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == bno_pkg::CMD_GAP_CYCLES - 1) begin
                        delay_cnt <= '0;
                        if (last_cmd) begin
                            initialized <= 1'b1;
                            state       <= bno_pkg::INIT_DONE;
                        end else begin
                            cmd   <= bno_pkg::cmd_t'(cmd + 2'd1);
                            state <= bno_pkg::INIT_ARM;
                        end
                    end
                end
                bno_pkg::INIT_DONE:  state <= bno_pkg::INIT_DONE;   // Reader owns the bus
                bno_pkg::INIT_ERROR: state <= bno_pkg::INIT_ERROR;
                default:             state <= bno_pkg::INIT_ERROR;
            endcase
        end
    end

    // No traffic once the timeout has fired
    a_no_req_in_error: assert property (@(posedge clk) disable iff (!rst_n)
        error |-> !init_req && !init_sel);

endmodule

/* bno_pkg.sv */
package bno_pkg;

    typedef logic [7:0]         byte_t;     // One SPI byte
    typedef logic [15:0]        len_t;      // SHTP length or payload count
    typedef logic signed [15:0] sample_t;   // Fixed-point sensor component

    // ==================================================
    // SHTP channels, report IDs, packet limits
    // ==================================================
    localparam byte_t CH_REPORTS          = 8'h03;   // Non-wake input reports
    localparam byte_t CH_GYRO_RV          = 8'h05;   // Gyro-integrated RV channel
    localparam byte_t RID_ROTATION_VECTOR = 8'h05;
    localparam byte_t RID_GYROSCOPE       = 8'h02;   // Calibrated gyro
    localparam len_t  HDR_BYTES           = 16'd4;   // Length LSB, MSB, channel, seq
    localparam len_t  MAX_PKT_LEN         = 16'd32766;

    // Delays in clk cycles
    localparam int DELAY_W            = 19;       // Holds the longest wait
    localparam int RESET_WAIT_CYCLES  = 300_000;  // Hub boot time
    localparam int WAKE_HOLD_CYCLES   = 450;      // PS0 low pulse
    localparam int INT_TIMEOUT_CYCLES = 150_000;  // Max wait for INT after wake
    localparam int CMD_GAP_CYCLES     = 30_000;   // Quiet time between commands
    localparam int NUM_CMDS           = 3;

    typedef enum logic [1:0] {
        CMD_PROD_ID,
        CMD_EN_ROTV,
        CMD_EN_GYRO
    } cmd_t;

    typedef enum logic [3:0] {
        INIT_WAIT_RESET,   // Power-up delay
        INIT_ARM,          // Decide on wake or direct send
        INIT_WAKE,         // PS0 held low
        INIT_WAIT_INT,     // Wait for hub ready
        INIT_START,        // Take CS, first byte
        INIT_SEND,
        INIT_GAP,
        INIT_DONE,
        INIT_ERROR
    } init_state_t;

    typedef enum logic [1:0] {
        RD_WAIT,
        RD_HDR,
        RD_PAYLOAD
    } rd_state_t;

    // Total bytes of a command, header included
    function automatic byte_t cmd_len(cmd_t cmd);
        return (cmd == CMD_PROD_ID) ? 8'd5 : 8'd17;
    endfunction

    // Command ROM
    function automatic byte_t cmd_byte(cmd_t cmd, byte_t idx);
        byte_t b;
        b = 8'h00;
        if (cmd == CMD_PROD_ID) begin
            case (idx)
                8'd0:    b = 8'h05;  // Length 5
                8'd2:    b = 8'h02;  // Control channel
                8'd4:    b = 8'hF9;  // Product ID request
                default: b = 8'h00;
            endcase
        end else begin
            case (idx)
                8'd0:    b = 8'd17;
                8'd2:    b = 8'h02;
                8'd3:    b = {6'd0, cmd};  // Seq 1 or 2
                8'd4:    b = 8'hFD;        // Set feature
                8'd5:    b = (cmd == CMD_EN_ROTV) ? RID_ROTATION_VECTOR : RID_GYROSCOPE;
                8'd9:    b = 8'h20;        // 20000 us interval, 50 Hz
                8'd10:   b = 8'h4E;
                default: b = 8'h00;        // Flags, sensitivity, interval MSBs, config
            endcase
        end
        return b;
    endfunction

endpackage

/* shtp_host_port.sv */
`timescale 1ns/1ps

module shtp_host_port (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           int_n,
    input  logic           init_sel,
    input  logic           init_req,
    input  bno_pkg::byte_t init_byte,
    input  logic           rd_sel,
    input  logic           rd_req,
    input  logic           spi_busy,
    input  logic           spi_rx_valid,
    input  bno_pkg::byte_t spi_rx_data,
    output logic           spi_start,
    output bno_pkg::byte_t spi_tx_data,
    output logic           cs_n,
    output logic           int_low,
    output logic           byte_done,
    output bno_pkg::byte_t rx_byte
);

    logic int_meta;
    logic int_sync;
    logic pending;  // Request waiting for an idle master
    logic want;

    // ==================================================
    // INT synchronizer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    assign int_low = ~int_sync;

    // Start pulse one cycle after the request, later if busy
    assign want = pending || init_req || rd_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            spi_start <= 1'b0;
        end else if (want && !spi_busy) begin
            pending   <= 1'b0;
            spi_start <= 1'b1;
        end else begin
            pending   <= want;
            spi_start <= 1'b0;
        end
    end

    // Reader clocks out zeros
    always_ff @(posedge clk) begin
        if (init_req)
            spi_tx_data <= init_byte;
        else if (rd_req)
            spi_tx_data <= 8'h00;
    end

    assign cs_n      = ~(init_sel || rd_sel);
    assign byte_done = spi_rx_valid;  // Same cycle as busy falls
    assign rx_byte   = spi_rx_data;

    // Bus owners never overlap
    a_sel_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(init_sel && rd_sel));

endmodule

/* shtp_report_reader.sv */
`timescale 1ns/1ps

module shtp_report_reader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable,      // Init done
    input  logic             int_low,
    input  logic             byte_done,
    input  bno_pkg::byte_t   rx_byte,
    output logic             rd_sel,
    output logic             rd_req,
    output logic             quat_valid,
    output bno_pkg::sample_t quat_w,
    output bno_pkg::sample_t quat_x,
    output bno_pkg::sample_t quat_y,
    output bno_pkg::sample_t quat_z,
    output logic             gyro_valid,
    output bno_pkg::sample_t gyro_x,
    output bno_pkg::sample_t gyro_y,
    output bno_pkg::sample_t gyro_z
);

    bno_pkg::rd_state_t state;
    logic [1:0]         hdr_idx;     // Header byte 0..3
    bno_pkg::len_t      pay_cnt;     // Payload byte index
    bno_pkg::len_t      pkt_len;     // Continuation bit cleared
    bno_pkg::byte_t     channel;
    bno_pkg::byte_t     report_id;
    bno_pkg::byte_t     lsb;         // Low half of current word
    bno_pkg::sample_t   word;
    bno_pkg::len_t      pay_last;
    logic               rx_ok;
    logic               len_ok;
    logic               report_ch;
    logic               rx_pay;
    logic               is_rv;
    logic               is_gyro;

    assign rx_ok     = byte_done && rd_sel;
    assign len_ok    = (pkt_len > bno_pkg::HDR_BYTES) && (pkt_len <= bno_pkg::MAX_PKT_LEN);
    assign pay_last  = pkt_len - bno_pkg::HDR_BYTES - 16'd1;
    assign report_ch = (channel == bno_pkg::CH_REPORTS) || (channel == bno_pkg::CH_GYRO_RV);
    assign rx_pay    = rx_ok && (state == bno_pkg::RD_PAYLOAD) && report_ch;
    assign is_rv     = (report_id == bno_pkg::RID_ROTATION_VECTOR);
    assign is_gyro   = (report_id == bno_pkg::RID_GYROSCOPE);
    assign word      = {rx_byte, lsb};  // Little-endian pair

    // ==================================================
    // Transfer control
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= bno_pkg::RD_WAIT;
            hdr_idx    <= '0;
            pay_cnt    <= '0;
            rd_sel     <= 1'b0;
            rd_req     <= 1'b0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            rd_req     <= 1'b0;
            quat_valid <= rx_pay && is_rv && (pay_cnt == 16'd11);   // W done
            gyro_valid <= rx_pay && is_gyro && (pay_cnt == 16'd9);  // Z done
            case (state)
                bno_pkg::RD_WAIT: begin
                    if (enable && int_low) begin
                        rd_sel  <= 1'b1;
                        rd_req  <= 1'b1;
                        hdr_idx <= '0;
                        state   <= bno_pkg::RD_HDR;
                    end
                end
                bno_pkg::RD_HDR: begin
                    if (rx_ok) begin
                        if (hdr_idx != 2'd3) begin
                            hdr_idx <= hdr_idx + 2'd1;
                            rd_req  <= 1'b1;
                        end else if (len_ok) begin
                            pay_cnt <= '0;
                            rd_req  <= 1'b1;
                            state   <= bno_pkg::RD_PAYLOAD;
                        end else begin
                            rd_sel <= 1'b0;  // Empty or bad length, drop CS
                            state  <= bno_pkg::RD_WAIT;
                        end
                    end
                end
                bno_pkg::RD_PAYLOAD: begin
                    if (rx_ok) begin
                        if (pay_cnt == pay_last) begin
                            rd_sel <= 1'b0;
                            state  <= bno_pkg::RD_WAIT;
                        end else begin
                            pay_cnt <= pay_cnt + 16'd1;
                            rd_req  <= 1'b1;
                        end
                    end
                end
                default: state <= bno_pkg::RD_WAIT;
            endcase
        end
    end

    // ==================================================
    // Header fields and sample words
    // ==================================================
    always_ff @(posedge clk) begin
        if (rx_ok && state == bno_pkg::RD_HDR) begin
            case (hdr_idx)
                2'd0:    pkt_len[7:0]  <= rx_byte;
                2'd1:    pkt_len[15:8] <= {1'b0, rx_byte[6:0]};  // Mask continuation
                2'd2:    channel       <= rx_byte;
                default: ;                                       // Seq not kept
            endcase
        end
        if (rx_pay) begin
            if (pay_cnt == 16'd0)
                report_id <= rx_byte;
            if (!pay_cnt[0])
                lsb <= rx_byte;  // Even index holds the low byte
            case (pay_cnt)
                16'd5: begin
                    if (is_rv)   quat_x <= word;
                    if (is_gyro) gyro_x <= word;
                end
                16'd7: begin
                    if (is_rv)   quat_y <= word;
                    if (is_gyro) gyro_y <= word;
                end
                16'd9: begin
                    if (is_rv)   quat_z <= word;
                    if (is_gyro) gyro_z <= word;
                end
                16'd11:  if (is_rv) quat_w <= word;  // Real part last
                default: ;
            endcase
        end
    end

    // One report type per packet
    a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(quat_valid && gyro_valid));

endmodule

/* spi_sensor_model.sv */
`timescale 1ns/1ps

module spi_sensor_model (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           spi_start,
    input  bno_pkg::byte_t spi_tx_data,
    input  logic           cs_n,
    output logic           spi_busy,
    output logic           spi_rx_valid,
    output bno_pkg::byte_t spi_rx_data,
    output logic           int_n
);

    localparam int BUSY_CYCLES = 8;  // Shift time of one byte

    bno_pkg::byte_t rd_queue[$];  // Bytes the hub plays back
    bno_pkg::byte_t wr_log[$];    // Bytes written while CS is low
    int             busy_cnt;

    initial begin
        spi_busy     = 1'b0;
        spi_rx_valid = 1'b0;
        spi_rx_data  = 8'h00;
        int_n        = 1'b1;  // Hub idle
        busy_cnt     = 0;
    end

    // ==================================================
    // SPI master and hub, driven on the falling edge
    // ==================================================
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_busy     <= 1'b0;
            spi_rx_valid <= 1'b0;
            busy_cnt     <= 0;
        end else begin
            spi_rx_valid <= 1'b0;
            if (!cs_n)
                int_n <= 1'b1;                // Hub drops its request once selected
            if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 1;
                if (busy_cnt == 1) begin
                    spi_busy     <= 1'b0;     // Done and data in the same cycle
                    spi_rx_valid <= 1'b1;
                    if (rd_queue.size() != 0)
                        spi_rx_data <= rd_queue.pop_front();
                    else
                        spi_rx_data <= 8'h00; // Nothing queued
                end
            end else if (spi_start) begin
                spi_busy <= 1'b1;
                busy_cnt <= BUSY_CYCLES;
                if (!cs_n)
                    wr_log.push_back(spi_tx_data);
            end
        end
    end

    task automatic push_byte(input bno_pkg::byte_t b);
        rd_queue.push_back(b);
    endtask

    task automatic set_int(input logic level);
        int_n = level;
    endtask

    task automatic clear();
        rd_queue.delete();
        wr_log.delete();
    endtask

    function automatic bno_pkg::byte_t logged_byte(input int idx);
        return wr_log[idx];
    endfunction

    function automatic int logged_count();
        return wr_log.size();
    endfunction

    function automatic int queued();
        return rd_queue.size();
    endfunction

endmodule

/* tb.f */
bno_pkg.sv
bno_init_seq.sv
shtp_report_reader.sv
shtp_host_port.sv
bno_hub.sv
spi_sensor_model.sv
tb_bno_hub.sv

/* tb_bno_hub.sv */
`timescale 1ns/1ps

module tb_bno_hub;

    localparam int     CLK_PERIOD   = 40;
    localparam int     RESET_CYCLES = 16;
    localparam int     BYTE_CYCLES  = 12;    // Busy time plus request and start
    localparam int     PKT_MARGIN   = 2000;  // Per packet slack
    localparam int     NUM_PKTS     = 5;
    localparam longint INIT_CYCLES  = bno_pkg::RESET_WAIT_CYCLES + 3 *
        (bno_pkg::INT_TIMEOUT_CYCLES + bno_pkg::WAKE_HOLD_CYCLES +
         bno_pkg::CMD_GAP_CYCLES + 17 * BYTE_CYCLES);
    localparam longint RUN_LIMIT_NS = (3 * INIT_CYCLES + NUM_PKTS * PKT_MARGIN) * CLK_PERIOD;
    localparam int     WAKE_LIMIT   = bno_pkg::RESET_WAIT_CYCLES + bno_pkg::CMD_GAP_CYCLES + 1000;
    localparam int     CS_LIMIT     = bno_pkg::WAKE_HOLD_CYCLES + 100;
    localparam int     ERR_CYCLES   = bno_pkg::RESET_WAIT_CYCLES + bno_pkg::WAKE_HOLD_CYCLES +
        bno_pkg::INT_TIMEOUT_CYCLES;

    logic             clk;
    logic             rst_n;
    logic             int_n;
    logic             spi_busy;
    logic             spi_rx_valid;
    bno_pkg::byte_t   spi_rx_data;
    logic             spi_start;
    bno_pkg::byte_t   spi_tx_data;
    logic             cs_n;
    logic             ps0_wake;
    logic             initialized;
    logic             error;
    logic             quat_valid;
    bno_pkg::sample_t quat_w;
    bno_pkg::sample_t quat_x;
    bno_pkg::sample_t quat_y;
    bno_pkg::sample_t quat_z;
    logic             gyro_valid;
    bno_pkg::sample_t gyro_x;
    bno_pkg::sample_t gyro_y;
    bno_pkg::sample_t gyro_z;

    int               quat_pulses = 0;
    int               gyro_pulses = 0;
    logic [31:0]      rng_state   = 32'd68;
    bno_pkg::byte_t   pkt[$];         // Packet under construction
    bno_pkg::sample_t exp_quat[4];    // x, y, z, w last decoded
    bno_pkg::sample_t exp_gyro[3];

    bno_hub          i_bno_hub (.*);
    spi_sensor_model i_sensor (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Valid strobes counted on the rising edge
    always @(posedge clk) begin
        if (quat_valid)
            quat_pulses = quat_pulses + 1;
        if (gyro_valid)
            gyro_pulses = gyro_pulses + 1;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s: expected %0h, actual %0h", test, exp, act));
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Bytes per command on the wire, header included
    function automatic int command_length(input int c);
        case (c)
            0:       return 5;   // Product ID request
            default: return 17;  // Set feature for rotation vector or gyro
        endcase
    endfunction

    task automatic apply_reset(input logic int_level);
        @(negedge clk);
        rst_n = 1'b0;
        i_sensor.set_int(int_level);
        i_sensor.clear();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic add_header(input bno_pkg::len_t len, input bno_pkg::byte_t ch);
        logic [31:0] r;
        r = next_random();
        pkt.delete();
        pkt.push_back(len[7:0]);  // Little-endian length
        pkt.push_back(len[15:8]);
        pkt.push_back(ch);
        pkt.push_back(r[7:0]);    // Sequence number
    endtask

    task automatic add_word(input bno_pkg::sample_t w);
        pkt.push_back(w[7:0]);
        pkt.push_back(w[15:8]);
    endtask

    // Queue the packet, pull INT and wait for the whole read
    task automatic send_packet(input string test);
        int cnt;
        int start;
        int i;
        start = i_sensor.logged_count();
        foreach (pkt[i])
            i_sensor.push_byte(pkt[i]);
        @(negedge clk);
        i_sensor.set_int(1'b0);
        cnt = 0;
        while (cs_n !== 1'b0) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > 50)
                abort_run({test, ": chip select never fell after INT"});
        end
        cnt = 0;
        while (cs_n !== 1'b1) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > pkt.size() * BYTE_CYCLES + 100)
                abort_run({test, ": packet read never finished"});
        end
        repeat (4) @(negedge clk);
        check({test, " bytes read"}, pkt.size(), i_sensor.logged_count() - start);
        check({test, " bytes left"}, 0, i_sensor.queued());
        // Reads clock out zeros
        for (i = start; i < i_sensor.logged_count(); i++)
            check($sformatf("%s write byte %0d", test, i - start), 0, i_sensor.logged_byte(i));
    endtask

    task automatic check_outputs(input string test);
        check({test, " quat x"}, exp_quat[0], quat_x);
        check({test, " quat y"}, exp_quat[1], quat_y);
        check({test, " quat z"}, exp_quat[2], quat_z);
        check({test, " quat w"}, exp_quat[3], quat_w);
        check({test, " gyro x"}, exp_gyro[0], gyro_x);
        check({test, " gyro y"}, exp_gyro[1], gyro_y);
        check({test, " gyro z"}, exp_gyro[2], gyro_z);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_values();
        check("reset cs_n", 1, cs_n);
        check("reset ps0_wake", 1, ps0_wake);
        check("reset spi_start", 0, spi_start);
        check("reset initialized", 0, initialized);
        check("reset error", 0, error);
        check("reset quat_valid", 0, quat_valid);
        check("reset gyro_valid", 0, gyro_valid);
    endtask

    task automatic test_init_sequence();
        int c;
        int i;
        int cnt;
        int prefix;
        prefix = 0;
        for (c = 0; c < bno_pkg::NUM_CMDS; c++) begin
            cnt = 0;
            while (ps0_wake !== 1'b0) begin
                @(negedge clk);
                cnt = cnt + 1;
                if (cnt > WAKE_LIMIT)
                    abort_run("ps0_wake never went low before a command");
            end
            check("init wake before command", prefix, i_sensor.logged_count());
            i_sensor.set_int(1'b0);  // Hub answers the wake
            cnt = 0;
            while (cs_n !== 1'b0) begin
                @(negedge clk);
                cnt = cnt + 1;
                if (cnt > CS_LIMIT)
                    abort_run("chip select never fell after INT in the wake phase");
            end
            check("init wake released with cs", 1, ps0_wake);
            prefix = prefix + command_length(c);
        end
        cnt = 0;
        while (initialized !== 1'b1) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > bno_pkg::CMD_GAP_CYCLES + 17 * BYTE_CYCLES + 1000)
                abort_run("initialized never rose after the last command");
        end
        check("init byte count", 39, i_sensor.logged_count());
        prefix = 0;
        for (c = 0; c < bno_pkg::NUM_CMDS; c++) begin
            for (i = 0; i < command_length(c); i++)
                check($sformatf("init cmd %0d byte %0d", c, i),
                      bno_pkg::cmd_byte(bno_pkg::cmd_t'(c), bno_pkg::byte_t'(i)),
                      i_sensor.logged_byte(prefix + i));
            prefix = prefix + command_length(c);
        end
        check("init error", 0, error);
    endtask

    task automatic test_rotation_vector(input string test);
        int          i;
        int          q0;
        int          g0;
        logic [31:0] r;
        add_header(16'd16, bno_pkg::CH_REPORTS);
        pkt.push_back(bno_pkg::RID_ROTATION_VECTOR);
        for (i = 0; i < 3; i++) begin
            r = next_random();
            pkt.push_back(r[7:0]);  // Seq, status, delay
        end
        for (i = 0; i < 4; i++) begin
            r = next_random();
            exp_quat[i] = r[15:0];
            add_word(exp_quat[i]);
        end
        q0 = quat_pulses;
        g0 = gyro_pulses;
        send_packet(test);
        check({test, " quat_valid pulses"}, q0 + 1, quat_pulses);
        check({test, " gyro_valid pulses"}, g0, gyro_pulses);
        check_outputs(test);
    endtask

    task automatic test_gyroscope();
        int          i;
        int          q0;
        int          g0;
        logic [31:0] r;
        add_header(16'd14, bno_pkg::CH_GYRO_RV);
        pkt.push_back(bno_pkg::RID_GYROSCOPE);
        for (i = 0; i < 3; i++) begin
            r = next_random();
            pkt.push_back(r[7:0]);
        end
        for (i = 0; i < 3; i++) begin
            r = next_random();
            exp_gyro[i] = r[15:0];
            add_word(exp_gyro[i]);
        end
        q0 = quat_pulses;
        g0 = gyro_pulses;
        send_packet("gyroscope");
        check("gyroscope gyro_valid pulses", g0 + 1, gyro_pulses);
        check("gyroscope quat_valid pulses", q0, quat_pulses);
        check_outputs("gyroscope");
    endtask

    // Channel 2 payload is read but never decoded
    task automatic test_other_channel();
        int          i;
        int          q0;
        int          g0;
        logic [31:0] r;
        add_header(16'd16, 8'h02);
        for (i = 0; i < 12; i++) begin
            r = next_random();
            pkt.push_back((i == 0) ? bno_pkg::RID_GYROSCOPE : r[7:0]);
        end
        q0 = quat_pulses;
        g0 = gyro_pulses;
        send_packet("control channel");
        check("control channel quat_valid pulses", q0, quat_pulses);
        check("control channel gyro_valid pulses", g0, gyro_pulses);
        check_outputs("control channel");
    endtask

    task automatic test_empty_packet();
        int q0;
        int g0;
        add_header(16'd4, bno_pkg::CH_REPORTS);  // Header only
        q0 = quat_pulses;
        g0 = gyro_pulses;
        send_packet("empty packet");
        check("empty packet quat_valid pulses", q0, quat_pulses);
        check("empty packet gyro_valid pulses", g0, gyro_pulses);
    endtask

    task automatic test_int_timeout();
        int cnt;
        apply_reset(1'b1);
        cnt = 0;
        while (error !== 1'b1) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cs_n !== 1'b1)
                abort_run("chip select fell while the hub never raised INT");
            if (cnt > ERR_CYCLES + 100)
                abort_run("error never rose after the INT timeout");
        end
        check("int timeout not early", 1, cnt >= ERR_CYCLES);
        repeat (10) @(negedge clk);
        check("int timeout cs_n", 1, cs_n);
        check("int timeout ps0_wake", 1, ps0_wake);
        check("int timeout error", 1, error);
        check("int timeout initialized", 0, initialized);
    endtask

    // INT already low, so the first command goes out without a wake
    task automatic test_awake_hub();
        int i;
        int cnt;
        apply_reset(1'b0);
        cnt = 0;
        while (cs_n !== 1'b0) begin
            @(negedge clk);
            cnt = cnt + 1;
            check("awake hub ps0_wake", 1, ps0_wake);
            if (cnt > bno_pkg::RESET_WAIT_CYCLES + 100)
                abort_run("chip select never fell with INT held low");
        end
        cnt = 0;
        while (i_sensor.logged_count() < 5) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > 5 * BYTE_CYCLES + 100)
                abort_run("product ID request was not fully written");
        end
        for (i = 0; i < 5; i++)
            check($sformatf("awake hub byte %0d", i),
                  bno_pkg::cmd_byte(bno_pkg::CMD_PROD_ID, bno_pkg::byte_t'(i)),
                  i_sensor.logged_byte(i));
    endtask

    // ==================================================
    // Sequence and watchdog
    // ==================================================
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        apply_reset(1'b1);
        test_reset_values();
        test_init_sequence();
        test_rotation_vector("rotation vector");
        test_gyroscope();
        test_other_channel();
        test_empty_packet();
        test_rotation_vector("rotation vector after empty packet");
        test_int_timeout();
        test_awake_hub();
        $display("all tests passed");
        $finish;
    end

    initial begin
        #(RUN_LIMIT_NS);
        abort_run("watchdog expired before the tests finished");
    end

endmodule
